/* all.f */
verilog/mem_bus_pkg.sv
verilog/irq_table_pkg.sv
verilog/mem_request_arbiter.sv
verilog/inflight_counter.sv
verilog/return_tag_queue.sv
verilog/io_bridge.sv
verilog/mist_bus_hub.sv
testbench/tb_memory_model.sv
testbench/tb_mist_bus_hub.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the bus hub testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f all.f --top-module tb_mist_bus_hub -Mdir obj_dir
output=$(./obj_dir/Vtb_mist_bus_hub)
echo "$output"
if echo "$output" | grep -qx "all tests passed"; then
	exit 0
else
	exit 1
fi

/* testbench/tb_mist_bus_hub.sv */
/*
	Testbench of the bus hub
	Random pipe, IO and table traffic against a latency memory model,
	checked every cycle against reference rules for grant, routing,
	in-flight limit, IO write acknowledge and table steering
*/
`timescale 1ns/1ps

module tb_mist_bus_hub;

	localparam int TIMEOUT = 200;

	logic iBUS_CLOCK;
	logic inRESET;
	logic inst_req, inst_lock, inst_valid, inst_busy;
	mem_bus_pkg::addr_t inst_addr;
	mem_bus_pkg::line_t inst_data;
	logic data_req, data_lock, data_rw, data_valid;
	mem_bus_pkg::order_t data_order;
	mem_bus_pkg::mask_t data_mask;
	mem_bus_pkg::addr_t data_addr;
	mem_bus_pkg::word_t data_wdata;
	mem_bus_pkg::line_t data_rdata;
	logic memory_req, memory_lock, memory_rw, memory_valid, memory_busy;
	mem_bus_pkg::order_t memory_order;
	mem_bus_pkg::mask_t memory_mask;
	mem_bus_pkg::addr_t memory_addr;
	mem_bus_pkg::word_t memory_data;
	mem_bus_pkg::line_t memory_rdata;
	logic io_req, io_rw, io_valid, periph_req, periph_rw, io_busy, periph_valid;
	mem_bus_pkg::addr_t io_addr;
	mem_bus_pkg::addr_t periph_addr;
	logic table_req, table_mask, table_valid;
	irq_table_pkg::irq_entry_t table_entry;
	irq_table_pkg::irq_level_t table_level;
	logic dps_table_req, dps_table_mask, dps_table_valid;
	irq_table_pkg::dps_entry_t dps_table_entry;
	irq_table_pkg::irq_level_t dps_table_level;

	// Memory model controls
	logic stall;
	logic hold_off;
	logic [1:0] latency_pick;

	// Scoreboard
	logic [31:0] seed;
	string phase;
	int errors;
	int outstanding;
	logic prev_write;
	logic have_last;
	mem_bus_pkg::owner_t last_owner;
	mem_bus_pkg::addr_t inst_exp [$];
	mem_bus_pkg::addr_t data_exp [$];
	mem_bus_pkg::owner_t owner_exp [$];

	mist_bus_hub i_mist_bus_hub(.*);

	tb_memory_model i_tb_memory_model(
		.iBUS_CLOCK(iBUS_CLOCK),
		.inRESET(inRESET),
		.stall(stall),
		.hold_off(hold_off),
		.latency_pick(latency_pick),
		.memory_req(memory_req),
		.memory_lock(memory_lock),
		.memory_addr(memory_addr),
		.memory_valid(memory_valid),
		.memory_busy(memory_busy),
		.memory_rdata(memory_rdata)
	);

	always #4 iBUS_CLOCK = ~iBUS_CLOCK;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Memory word for an address
	function automatic mem_bus_pkg::line_t ref_word(input mem_bus_pkg::addr_t a);
		return {~a, a};
	endfunction

	// Peripheral system owns entries 36 and 37
	function automatic logic ref_dps_req(input logic req, input irq_table_pkg::irq_entry_t e);
		return req && (e == 6'd36 || e == 6'd37);
	endfunction

	function automatic irq_table_pkg::dps_entry_t ref_dps_entry(
		input irq_table_pkg::irq_entry_t e);
		return 2'(e - 6'd36);
	endfunction

	task automatic check_value(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		assert (exp === act) else begin
			errors++;
			$display("** Error %s %s: expected %h, actual %h", phase, name, exp, act);
		end
	endtask

	task automatic report_failure(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	// One cycle of random traffic, steady keeps both requests up
	task automatic drive_cycle(input logic inst_on, input logic data_on, input logic busy_on,
		input logic steady);
		@(posedge iBUS_CLOCK);
		seed = xorshift(seed);
		inst_req <= inst_on && (steady || seed[0]);
		data_req <= data_on && (steady || seed[1]);
		data_rw <= seed[2];
		data_order <= seed[4] ? mem_bus_pkg::ORDER_WORD :
			(seed[3] ? mem_bus_pkg::ORDER_HALF : mem_bus_pkg::ORDER_BYTE);
		data_mask <= seed[8:5];
		inst_busy <= busy_on && seed[9];
		latency_pick <= seed[11:10];
		hold_off <= (seed[14:12] == 3'd0);
		io_req <= seed[15];
		io_rw <= seed[16];
		io_busy <= seed[17];
		periph_valid <= seed[18] && seed[19];
		table_req <= seed[20];
		table_entry <= 6'd33 + 6'(seed[23:21]);
		table_mask <= seed[24];
		table_valid <= seed[25];
		table_level <= seed[27:26];
		seed = xorshift(seed);
		inst_addr <= seed;
		io_addr <= ~seed;
		seed = xorshift(seed);
		data_addr <= seed;
		data_wdata <= {seed[15:0], seed[31:16]};
	endtask

	// Traffic until the in-flight count reaches target
	task automatic run_until(input int target, input logic inst_on, input logic data_on,
		input logic steady);
		int guard;
		guard = 0;
		while (outstanding != target && guard < TIMEOUT) begin
			drive_cycle(inst_on, data_on, 1'b0, steady);
			guard++;
		end
		if (outstanding != target) begin
			report_failure($sformatf("Timeout in %s waiting for %0d requests in flight",
				phase, target));
		end
	endtask

	task automatic compare_cycle();
		logic inst_take;
		logic data_take;
		logic transfer;
		logic head_inst;
		mem_bus_pkg::addr_t head_addr;
		inst_take = inst_req && !inst_lock;
		data_take = data_req && !data_lock;
		transfer = memory_req && !memory_lock;
		// Window full holds the bus off
		if (outstanding == 4) begin
			check_value("memory_req at limit", 64'(1'b0), 64'(memory_req));
		end
		check_value("transfer", 64'(inst_take || data_take), 64'(transfer));
		check_value("double accept", 64'(1'b0), 64'(inst_take && data_take));
		if (inst_take) begin
			check_value("inst addr", 64'(inst_addr), 64'(memory_addr));
			check_value("inst order", 64'(mem_bus_pkg::ORDER_WORD), 64'(memory_order));
			check_value("inst mask", 64'(4'hf), 64'(memory_mask));
			check_value("inst rw", 64'(1'b0), 64'(memory_rw));
		end
		if (data_take) begin
			check_value("data addr", 64'(data_addr), 64'(memory_addr));
			check_value("data order", 64'(data_order), 64'(memory_order));
			check_value("data mask", 64'(data_mask), 64'(memory_mask));
			check_value("data rw", 64'(data_rw), 64'(memory_rw));
			check_value("data wdata", 64'(data_wdata), 64'(memory_data));
		end
		// Contention goes to the pipe not served last
		if (inst_req && data_req && transfer && have_last) begin
			check_value("alternation", 64'(last_owner == mem_bus_pkg::OWNER_INST), 64'(data_take));
		end
		// Returns, oldest first
		assert (!memory_valid || owner_exp.size() != 0) else begin
			report_failure($sformatf("Memory return in %s with no request in flight", phase));
		end
		if (memory_valid && owner_exp.size() != 0) begin
			head_inst = (owner_exp[0] == mem_bus_pkg::OWNER_INST);
			check_value("inst_valid", 64'(head_inst), 64'(inst_valid));
			check_value("data_valid", 64'(!head_inst), 64'(data_valid));
			check_value("memory_busy", 64'(head_inst && inst_busy), 64'(memory_busy));
			head_addr = head_inst ? inst_exp[0] : data_exp[0];
			check_value(head_inst ? "inst_data" : "data_rdata", ref_word(head_addr),
				head_inst ? inst_data : data_rdata);
			if (!(head_inst && inst_busy)) begin
				if (head_inst) begin
					void'(inst_exp.pop_front());
				end
				else begin
					void'(data_exp.pop_front());
				end
				void'(owner_exp.pop_front());
				outstanding--;
			end
		end
		else begin
			check_value("stray valid", 64'(1'b0), 64'(inst_valid || data_valid));
		end
		if (transfer) begin
			if (data_take) begin
				data_exp.push_back(data_addr);
				owner_exp.push_back(mem_bus_pkg::OWNER_DATA);
				last_owner = mem_bus_pkg::OWNER_DATA;
			end
			else begin
				inst_exp.push_back(inst_addr);
				owner_exp.push_back(mem_bus_pkg::OWNER_INST);
				last_owner = mem_bus_pkg::OWNER_INST;
			end
			have_last = 1'b1;
			outstanding++;
		end
		assert (outstanding <= 4) else report_failure("More than four requests in flight");
		// IO request passes to the peripheral controller
		check_value("periph request", 64'({io_req, io_rw, io_addr}),
			64'({periph_req, periph_rw, periph_addr}));
		// IO acknowledge one cycle after a taken write
		check_value("io_valid", 64'(periph_valid || prev_write), 64'(io_valid));
		prev_write = io_req && io_rw && !io_busy;
		check_value("dps_table_req", 64'(ref_dps_req(table_req, table_entry)),
			64'(dps_table_req));
		if (ref_dps_req(table_req, table_entry)) begin
			check_value("dps_table_entry", 64'(ref_dps_entry(table_entry)), 64'(dps_table_entry));
		end
		check_value("table flags", 64'({table_mask, table_valid, table_level}),
			64'({dps_table_mask, dps_table_valid, dps_table_level}));
	endtask

	// Outputs settled mid-cycle
	always @(negedge iBUS_CLOCK) begin
		if (inRESET === 1'b1) begin
			compare_cycle();
		end
	end

	initial begin
		seed = 32'hf0990bd7;
		errors = 0;
		outstanding = 0;
		prev_write = 1'b0;
		have_last = 1'b0;
		last_owner = mem_bus_pkg::OWNER_DATA;
		phase = "reset";
		inRESET <= 1'b0;
		iBUS_CLOCK = 1'b0;
		inst_req <= 1'b0;
		inst_addr <= '0;
		inst_busy <= 1'b0;
		data_req <= 1'b0;
		data_order <= mem_bus_pkg::ORDER_WORD;
		data_mask <= '0;
		data_rw <= 1'b0;
		data_addr <= '0;
		data_wdata <= '0;
		io_req <= 1'b0;
		io_rw <= 1'b0;
		io_addr <= '0;
		io_busy <= 1'b0;
		periph_valid <= 1'b0;
		table_req <= 1'b0;
		table_entry <= '0;
		table_mask <= 1'b0;
		table_valid <= 1'b0;
		table_level <= '0;
		stall <= 1'b0;
		hold_off <= 1'b0;
		latency_pick <= '0;
		repeat (4) @(posedge iBUS_CLOCK);
		inRESET <= 1'b1;
		phase = "inst_read";
		repeat (80) drive_cycle(1'b1, 1'b0, 1'b1, 1'b0);
		run_until(0, 1'b0, 1'b0, 1'b0);
		phase = "data_rw";
		repeat (80) drive_cycle(1'b0, 1'b1, 1'b0, 1'b0);
		run_until(0, 1'b0, 1'b0, 1'b0);
		phase = "contention";
		repeat (80) drive_cycle(1'b1, 1'b1, 1'b1, 1'b1);
		run_until(0, 1'b0, 1'b0, 1'b0);
		// Memory stalled, window must close at four
		phase = "limit";
		stall <= 1'b1;
		run_until(4, 1'b1, 1'b1, 1'b1);
		repeat (10) drive_cycle(1'b1, 1'b1, 1'b0, 1'b1);
		check_value("in flight", 64'(4), 64'(outstanding));
		stall <= 1'b0;
		run_until(0, 1'b0, 1'b0, 1'b0);
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("all tests passed");
		end
		else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* testbench/tb_memory_model.sv */
/*
	Memory model for the bus hub testbench
	Takes every transfer, answers in request order after 1 to 4 cycles
	with the inverted address above the address, holds a return while
	busy and can be stalled or locked from outside
*/
`timescale 1ns/1ps

module tb_memory_model(
	input logic iBUS_CLOCK,
	input logic inRESET,
	// Test controls
	input logic stall,
	input logic hold_off,
	input logic [1:0] latency_pick,
	// Memory bus
	input logic memory_req,
	output logic memory_lock,
	input mem_bus_pkg::addr_t memory_addr,
	output logic memory_valid,
	input logic memory_busy,
	output mem_bus_pkg::line_t memory_rdata
);

	// Pending requests, oldest first
	mem_bus_pkg::addr_t addr_q [$];
	int due_q [$];
	int cycle;

	assign memory_lock = hold_off;

	always @(posedge iBUS_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			addr_q.delete();
			due_q.delete();
			cycle = 0;
			memory_valid <= 1'b0;
			memory_rdata <= '0;
		end
		else begin
			cycle = cycle + 1;
			// Return taken in the cycle that just ended
			if (memory_valid && !memory_busy) begin
				void'(addr_q.pop_front());
				void'(due_q.pop_front());
			end
			// New transfer, due 1 to 4 cycles later
			if (memory_req && !memory_lock) begin
				addr_q.push_back(memory_addr);
				due_q.push_back(cycle + int'(latency_pick));
			end
			// A held return stays up even when stalled
			if (addr_q.size() != 0 && due_q[0] <= cycle &&
				(!stall || (memory_valid && memory_busy))) begin
				memory_valid <= 1'b1;
				memory_rdata <= {~addr_q[0], addr_q[0]};
			end
			else begin
				memory_valid <= 1'b0;
			end
		end
	end

endmodule

/* verilog/mist_bus_hub.sv */
/*
	Bus hub of the processor wrapper
	Joins the instruction and data pipes onto one memory bus with a
	bounded number of requests in flight, returns each word to its
	pipe, and handles IO write acknowledge and interrupt table routing
*/
`timescale 1ns/1ps

module mist_bus_hub(
	input logic iBUS_CLOCK,
	input logic inRESET,
	// Instruction pipe
	input logic inst_req,
	output logic inst_lock,
	input mem_bus_pkg::addr_t inst_addr,
	output logic inst_valid,
	input logic inst_busy,
	output mem_bus_pkg::line_t inst_data,
	// Data pipe, 1 = write
	input logic data_req,
	output logic data_lock,
	input mem_bus_pkg::order_t data_order,
	input mem_bus_pkg::mask_t data_mask,
	input logic data_rw,
	input mem_bus_pkg::addr_t data_addr,
	input mem_bus_pkg::word_t data_wdata,
	output logic data_valid,
	output mem_bus_pkg::line_t data_rdata,
	// Memory bus
	output logic memory_req,
	input logic memory_lock,
	output mem_bus_pkg::order_t memory_order,
	output mem_bus_pkg::mask_t memory_mask,
	output logic memory_rw,
	output mem_bus_pkg::addr_t memory_addr,
	output mem_bus_pkg::word_t memory_data,
	input logic memory_valid,
	output logic memory_busy,
	input mem_bus_pkg::line_t memory_rdata,
	// IO from the core
	input logic io_req,
	input logic io_rw,
	input mem_bus_pkg::addr_t io_addr,
	output logic io_valid,
	// Peripheral controller
	output logic periph_req,
	output logic periph_rw,
	output mem_bus_pkg::addr_t periph_addr,
	input logic io_busy,
	input logic periph_valid,
	// Interrupt table from the core
	input logic table_req,
	input irq_table_pkg::irq_entry_t table_entry,
	input logic table_mask,
	input logic table_valid,
	input irq_table_pkg::irq_level_t table_level,
	// Peripheral system table port
	output logic dps_table_req,
	output irq_table_pkg::dps_entry_t dps_table_entry,
	output logic dps_table_mask,
	output logic dps_table_valid,
	output irq_table_pkg::irq_level_t dps_table_level
);

	logic full;
	logic empty;
	logic push;
	logic pop;
	mem_bus_pkg::owner_t push_owner;
	mem_bus_pkg::count_t count;

	mem_request_arbiter i_mem_request_arbiter(
		.iBUS_CLOCK(iBUS_CLOCK),
		.inRESET(inRESET),
		.inst_req(inst_req),
		.inst_lock(inst_lock),
		.inst_addr(inst_addr),
		.data_req(data_req),
		.data_lock(data_lock),
		.data_order(data_order),
		.data_mask(data_mask),
		.data_rw(data_rw),
		.data_addr(data_addr),
		.data_wdata(data_wdata),
		.full(full),
		.memory_req(memory_req),
		.memory_lock(memory_lock),
		.memory_order(memory_order),
		.memory_mask(memory_mask),
		.memory_rw(memory_rw),
		.memory_addr(memory_addr),
		.memory_data(memory_data),
		.push(push),
		.push_owner(push_owner)
	);

	inflight_counter i_inflight_counter(
		.iBUS_CLOCK(iBUS_CLOCK),
		.inRESET(inRESET),
		.push(push),
		.pop(pop),
		.full(full),
		.empty(empty),
		.count(count)
	);

	return_tag_queue i_return_tag_queue(
		.iBUS_CLOCK(iBUS_CLOCK),
		.inRESET(inRESET),
		.push(push),
		.push_owner(push_owner),
		.count(count),
		.pop(pop),
		.memory_valid(memory_valid),
		.memory_busy(memory_busy),
		.memory_rdata(memory_rdata),
		.inst_valid(inst_valid),
		.inst_busy(inst_busy),
		.inst_data(inst_data),
		.data_valid(data_valid),
		.data_rdata(data_rdata)
	);

	io_bridge i_io_bridge(
		.iBUS_CLOCK(iBUS_CLOCK),
		.inRESET(inRESET),
		.io_req(io_req),
		.io_rw(io_rw),
		.io_busy(io_busy),
		.periph_valid(periph_valid),
		.io_valid(io_valid),
		.table_req(table_req),
		.table_entry(table_entry),
		.dps_table_req(dps_table_req),
		.dps_table_entry(dps_table_entry)
	);

	// IO request goes on to the peripheral controller
	assign periph_req = io_req;
	assign periph_rw = io_rw;
	assign periph_addr = io_addr;

	// Flags are for the peripheral system as they are
	assign dps_table_mask = table_mask;
	assign dps_table_valid = table_valid;
	assign dps_table_level = table_level;

	// Nothing may come back once the window has drained
	a_no_return_when_empty: assert property (
		@(posedge iBUS_CLOCK) disable iff (!inRESET)
		empty |-> !memory_valid
	);

endmodule

/* verilog/io_bridge.sv */
/*
	IO bridge
	Acknowledges IO writes one cycle after they are taken, merged with
	the peripheral's own valid, and picks out interrupt table writes
	for the default peripheral system
*/
`timescale 1ns/1ps

module io_bridge(
	input logic iBUS_CLOCK,
	input logic inRESET,
	// IO request from the core
	input logic io_req,
	input logic io_rw,
	input logic io_busy,
	// Read data ready at the peripheral
	input logic periph_valid,
	output logic io_valid,
	// Interrupt table write
	input logic table_req,
	input irq_table_pkg::irq_entry_t table_entry,
	output logic dps_table_req,
	output irq_table_pkg::dps_entry_t dps_table_entry
);

	logic b_write_ack;
	logic entry_hit;
	irq_table_pkg::irq_entry_t entry_offset;

	// One pulse per taken write, a cycle later
	always_ff @(posedge iBUS_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_write_ack <= 1'b0;
		end
		else begin
			b_write_ack <= io_req && io_rw && !io_busy;
		end
	end

	// Writes carry no peripheral reply
	assign io_valid = periph_valid || b_write_ack;

	// Entry window of the peripheral system
	assign entry_offset = table_entry - irq_table_pkg::DPS_ENTRY_BASE;
	assign entry_hit = (table_entry >= irq_table_pkg::DPS_ENTRY_BASE) &&
		(entry_offset < irq_table_pkg::DPS_ENTRY_COUNT);

	assign dps_table_req = table_req && entry_hit;
	// Local entry number, offset from the base
	assign dps_table_entry = irq_table_pkg::dps_entry_t'(entry_offset);

endmodule

/* verilog/return_tag_queue.sv */
/*
	Return tag queue
	Keeps the owner of each request in flight, oldest first, and steers
	every returned memory word to the pipe that asked for it. Holds the
	memory return while the instruction pipe is busy.
*/
`timescale 1ns/1ps

module return_tag_queue(
	input logic iBUS_CLOCK,
	input logic inRESET,
	// From the arbiter
	input logic push,
	input mem_bus_pkg::owner_t push_owner,
	// Occupancy from the counter
	input mem_bus_pkg::count_t count,
	output logic pop,
	// Memory return
	input logic memory_valid,
	output logic memory_busy,
	input mem_bus_pkg::line_t memory_rdata,
	// Instruction pipe return
	output logic inst_valid,
	input logic inst_busy,
	output mem_bus_pkg::line_t inst_data,
	// Data pipe return
	output logic data_valid,
	output mem_bus_pkg::line_t data_rdata
);

	// Entry 0 is the oldest
	mem_bus_pkg::owner_t tags [mem_bus_pkg::MAX_INFLIGHT];
	mem_bus_pkg::owner_t shifted [mem_bus_pkg::MAX_INFLIGHT];
	mem_bus_pkg::count_t wr_slot;
	logic head_inst;
	logic head_data;

	// Head only meaningful with something in flight
	assign head_inst = (count != '0) && (tags[0] == mem_bus_pkg::OWNER_INST);
	assign head_data = (count != '0) && (tags[0] == mem_bus_pkg::OWNER_DATA);

	// Only the fetch side can stall
	assign memory_busy = head_inst && inst_busy;
	assign pop = memory_valid && !memory_busy;

	assign inst_valid = memory_valid && head_inst;
	assign data_valid = memory_valid && head_data;
	assign inst_data = memory_rdata;
	assign data_rdata = memory_rdata;

	// Slot after the youngest, one lower when the head leaves
	assign wr_slot = pop ? count - mem_bus_pkg::count_t'(1) : count;

	// Queue moved down by one
	always_comb begin
		for (int i = 0; i < mem_bus_pkg::MAX_INFLIGHT - 1; i++) begin
			shifted[i] = tags[i + 1];
		end
		shifted[mem_bus_pkg::MAX_INFLIGHT - 1] = tags[mem_bus_pkg::MAX_INFLIGHT - 1];
	end

	// Tag storage
	always_ff @(posedge iBUS_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int i = 0; i < mem_bus_pkg::MAX_INFLIGHT; i++) begin
				tags[i] <= mem_bus_pkg::OWNER_INST;
			end
		end
		else begin
			for (int i = 0; i < mem_bus_pkg::MAX_INFLIGHT; i++) begin
				if (push && wr_slot == mem_bus_pkg::count_t'(i)) begin
					tags[i] <= push_owner;
				end
				else if (pop) begin
					tags[i] <= shifted[i];
				end
			end
		end
	end

endmodule

/* verilog/inflight_counter.sv */
/*
	In-flight counter
	Counts memory requests sent but not yet returned and flags an
	empty or a full window
*/
`timescale 1ns/1ps

module inflight_counter(
	input logic iBUS_CLOCK,
	input logic inRESET,
	// Transfer accepted by memory
	input logic push,
	// Return taken by a pipe
	input logic pop,
	output logic full,
	output logic empty,
	output mem_bus_pkg::count_t count
);

	mem_bus_pkg::count_t b_count;

	always_ff @(posedge iBUS_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_count <= '0;
		end
		else begin
			case ({push, pop})
				2'b10: b_count <= b_count + mem_bus_pkg::count_t'(1);
				2'b01: b_count <= b_count - mem_bus_pkg::count_t'(1);
				// Both or none, level unchanged
				default: b_count <= b_count;
			endcase
		end
	end

	assign count = b_count;
	assign full = (b_count == mem_bus_pkg::count_t'(mem_bus_pkg::MAX_INFLIGHT));
	assign empty = (b_count == '0);

	// A return always has a request behind it
	a_no_pop_when_empty: assert property (
		@(posedge iBUS_CLOCK) disable iff (!inRESET)
		pop |-> !empty
	);

	// Window bound holds across arbiter and memory
	a_count_bound: assert property (
		@(posedge iBUS_CLOCK) disable iff (!inRESET)
		b_count <= mem_bus_pkg::count_t'(mem_bus_pkg::MAX_INFLIGHT)
	);

endmodule

/* verilog/mem_request_arbiter.sv */
/*
	Memory request arbiter
	Grants the shared memory bus to the instruction pipe or the data
	pipe, alternating priority on contention, and drives the winner's
	fields onto the bus. Every transfer pushes its owner tag.
*/
`timescale 1ns/1ps

module mem_request_arbiter(
	input logic iBUS_CLOCK,
	input logic inRESET,
	// Instruction pipe
	input logic inst_req,
	output logic inst_lock,
	input mem_bus_pkg::addr_t inst_addr,
	// Data pipe
	input logic data_req,
	output logic data_lock,
	input mem_bus_pkg::order_t data_order,
	input mem_bus_pkg::mask_t data_mask,
	input logic data_rw,
	input mem_bus_pkg::addr_t data_addr,
	input mem_bus_pkg::word_t data_wdata,
	// In-flight window closed
	input logic full,
	// Memory bus
	output logic memory_req,
	input logic memory_lock,
	output mem_bus_pkg::order_t memory_order,
	output mem_bus_pkg::mask_t memory_mask,
	output logic memory_rw,
	output mem_bus_pkg::addr_t memory_addr,
	output mem_bus_pkg::word_t memory_data,
	// Tag queue
	output logic push,
	output mem_bus_pkg::owner_t push_owner
);

	// Pipe granted on the last transfer
	mem_bus_pkg::owner_t b_last_grant;
	logic grant_inst;
	logic grant_data;

	// Alone wins, on contention the pipe not served last
	assign grant_inst = inst_req && (!data_req || b_last_grant == mem_bus_pkg::OWNER_DATA);
	assign grant_data = data_req && (!inst_req || b_last_grant == mem_bus_pkg::OWNER_INST);

	// Nothing leaves while the window is full
	assign memory_req = (inst_req || data_req) && !full;

	// Loser waits too
	assign inst_lock = full || memory_lock || (inst_req && !grant_inst);
	assign data_lock = full || memory_lock || (data_req && !grant_data);

	// Transfer taken by memory
	assign push = memory_req && !memory_lock;
	assign push_owner = grant_data ? mem_bus_pkg::OWNER_DATA : mem_bus_pkg::OWNER_INST;

	// Field mux
	always_comb begin
		if (grant_data) begin
			memory_order = data_order;
			memory_mask = data_mask;
			memory_rw = data_rw;
			memory_addr = data_addr;
			memory_data = data_wdata;
		end
		else begin
			// Fetch is always a full word read
			memory_order = mem_bus_pkg::ORDER_WORD;
			memory_mask = mem_bus_pkg::FULL_MASK;
			memory_rw = 1'b0;
			memory_addr = inst_addr;
			memory_data = '0;
		end
	end

	// Last grant moves only on a real transfer
	always_ff @(posedge iBUS_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_last_grant <= mem_bus_pkg::OWNER_DATA;
		end
		else if (push) begin
			b_last_grant <= push_owner;
		end
	end

endmodule

/* verilog/irq_table_pkg.sv */
/*
	Interrupt configuration table definitions
	Entry and level widths of the global table and the window of
	entries owned by the default peripheral system
*/
package irq_table_pkg;

	// Global table entry number
	typedef logic [5:0] irq_entry_t;

	// Trigger level
	typedef logic [1:0] irq_level_t;

	// Entry number inside the peripheral system
	typedef logic [1:0] dps_entry_t;

	// First global entry of the peripheral system
	localparam irq_entry_t DPS_ENTRY_BASE = 6'd36;

	// Entries that belong to it
	localparam irq_entry_t DPS_ENTRY_COUNT = 6'd2;

endpackage

/* verilog/mem_bus_pkg.sv */
/*
	Memory bus definitions
	Widths of address, data and lane mask on the shared memory bus,
	access size codes, the owner tag of a request and the depth of
	the in-flight window
*/
package mem_bus_pkg;

	// Byte address
	typedef logic [31:0] addr_t;

	// Write data and IO data
	typedef logic [31:0] word_t;

	// Returned memory word, two words wide
	typedef logic [63:0] line_t;

	// One enable bit per byte lane
	typedef logic [3:0] mask_t;

	// Access size, same code as the core
	typedef enum logic [1:0] {
		ORDER_BYTE = 2'h0,
		ORDER_HALF = 2'h1,
		ORDER_WORD = 2'h2,
		ORDER_NONE = 2'h3
	} order_t;

	// Pipe that issued a request
	typedef enum logic {
		OWNER_INST = 1'b0,
		OWNER_DATA = 1'b1
	} owner_t;

	// Requests in flight, 0 up to MAX_INFLIGHT
	typedef logic [2:0] count_t;

	// Deepest in-flight window
	localparam int MAX_INFLIGHT = 4;

	// All byte lanes on
	localparam mask_t FULL_MASK = 4'hf;

endpackage
